//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_video_frame_buffer
FILELIST = files.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep '\.sv$$' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- files.f
logic/frame_buffer_pkg.sv
logic/buffer_manager.sv
logic/frame_writer.sv
logic/frame_reader.sv
logic/mem_port.sv
logic/video_frame_buffer.sv
verification/psram_model.sv
verification/tb_video_frame_buffer.sv

//--- logic/buffer_manager.sv
module buffer_manager
    import frame_buffer_pkg::*;
#(
    parameter int FRAME_WIDTH   = 640,
    parameter int FRAME_HEIGHT  = 480,
    parameter int STARTUP_DELAY = 152
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      init_done_i,
    input  logic      write_done_i,
    input  logic      read_done_i,
    output logic      write_start_o,
    output logic      read_start_o,
    output mem_addr_t write_base_o,
    output mem_addr_t read_base_o
);

    localparam int FRAME_WORDS = FRAME_WIDTH * FRAME_HEIGHT / 2;
    localparam int DELAY_W     = $clog2(STARTUP_DELAY + 1);

    session_state_e     up_state;
    session_state_e     dn_state;
    buffer_state_e      buf_state [NUM_BUFFERS];
    buf_idx_t           up_idx;
    buf_idx_t           dn_idx;
    buf_idx_t           up_pick;
    buf_idx_t           dn_pick;
    logic [DELAY_W-1:0] startup_cnt;
    logic               startup_done;
    logic               up_req;
    logic               dn_req;
    logic               up_holds;
    logic               dn_holds;
    logic               up_grant;
    logic               dn_grant;

    function automatic session_state_e session_next(
        input session_state_e st,
        input logic           ready,
        input logic           grant,
        input logic           done
    );
        session_state_e nxt;
        nxt = st;
        case (st)
            S_IDLE:         nxt = ready ? S_LOCK : S_START_WAIT;
            S_START_WAIT:   nxt = ready ? S_LOCK : S_START_WAIT;
            S_LOCK:         nxt = grant ? S_FIND : S_LOCK;
            S_FIND:         nxt = S_SELECT;
            S_SELECT:       nxt = S_START_FRAME;
            S_START_FRAME:  nxt = S_FRAME_WAIT;
            S_FRAME_WAIT:   nxt = done ? S_RELEASE_WAIT : S_FRAME_WAIT;
            S_RELEASE_WAIT: nxt = grant ? S_RELEASE : S_RELEASE_WAIT;
            S_RELEASE:      nxt = S_IDLE;
            default:        nxt = S_IDLE;
        endcase
        return nxt;
    endfunction

    // highest index of the best tier present
    function automatic buf_idx_t pick_buffer(
        input buffer_state_e tbl [NUM_BUFFERS],
        input buffer_state_e first,
        input buffer_state_e second,
        input buffer_state_e third
    );
        buffer_state_e order [3];
        buf_idx_t      idx;
        order[0] = first;
        order[1] = second;
        order[2] = third;
        idx = '0;
        // walk the worst tier first, better tiers overwrite
        for (int p = 2; p >= 0; p--) begin
            for (int i = 0; i < NUM_BUFFERS; i++) begin
                if (tbl[i] == order[p]) begin
                    idx = buf_idx_t'(i);
                end
            end
        end
        return idx;
    endfunction

    function automatic mem_addr_t base_of(input buf_idx_t idx);
        return mem_addr_t'(idx) * mem_addr_t'(FRAME_WORDS);
    endfunction

    assign startup_done = (startup_cnt == DELAY_W'(STARTUP_DELAY));

    // metadata lock, held from find through select and over release
    assign up_req   = (up_state == S_LOCK) || (up_state == S_RELEASE_WAIT);
    assign dn_req   = (dn_state == S_LOCK) || (dn_state == S_RELEASE_WAIT);
    assign up_holds = (up_state == S_FIND) || (up_state == S_SELECT) || (up_state == S_RELEASE);
    assign dn_holds = (dn_state == S_FIND) || (dn_state == S_SELECT) || (dn_state == S_RELEASE);
    assign up_grant = up_req && !dn_holds;
    assign dn_grant = dn_req && !up_holds && !up_req;

    assign up_pick = pick_buffer(buf_state, BUF_DISPLAYED, BUF_AVAILABLE, BUF_UPDATED);
    assign dn_pick = pick_buffer(buf_state, BUF_UPDATED, BUF_AVAILABLE, BUF_DISPLAYED);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            up_state      <= S_IDLE;
            dn_state      <= S_IDLE;
            startup_cnt   <= '0;
            write_start_o <= 1'b0;
            read_start_o  <= 1'b0;
            for (int i = 0; i < NUM_BUFFERS; i++) begin
                buf_state[i] <= BUF_AVAILABLE;
            end
        end else begin
            up_state      <= session_next(up_state, startup_done, up_grant, write_done_i);
            dn_state      <= session_next(dn_state, startup_done, dn_grant, read_done_i);
            write_start_o <= (up_state == S_SELECT);
            read_start_o  <= (dn_state == S_SELECT);
            if (init_done_i && !startup_done) begin
                startup_cnt <= startup_cnt + 1'b1;
            end
            if (up_state == S_SELECT) begin
                buf_state[up_idx] <= BUF_WRITE_BUSY;
            end else if (up_state == S_RELEASE) begin
                buf_state[up_idx] <= BUF_UPDATED;
            end
            if (dn_state == S_SELECT) begin
                buf_state[dn_idx] <= BUF_READ_BUSY;
            end else if (dn_state == S_RELEASE) begin
                buf_state[dn_idx] <= BUF_DISPLAYED;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (up_state == S_FIND) begin
            up_idx <= up_pick;
        end
        if (dn_state == S_FIND) begin
            dn_idx <= dn_pick;
        end
        if (up_state == S_SELECT) begin
            write_base_o <= base_of(up_idx);
        end
        if (dn_state == S_SELECT) begin
            read_base_o <= base_of(dn_idx);
        end
    end

endmodule

//--- logic/frame_buffer_pkg.sv
package frame_buffer_pkg;

    // memory side widths
    typedef logic [20:0] mem_addr_t;
    typedef logic [31:0] mem_word_t;

    // one rgb565 pixel
    typedef logic [15:0] pixel_t;

    typedef logic [1:0] buf_idx_t;

    localparam int NUM_BUFFERS = 3;

    typedef enum logic [2:0] {
        BUF_AVAILABLE,
        BUF_WRITE_BUSY,
        BUF_READ_BUSY,
        BUF_DISPLAYED,
        BUF_UPDATED
    } buffer_state_e;

    // shared by the upload and download sessions
    typedef enum logic [3:0] {
        S_IDLE,
        S_START_WAIT,
        S_LOCK,
        S_FIND,
        S_SELECT,
        S_START_FRAME,
        S_FRAME_WAIT,
        S_RELEASE_WAIT,
        S_RELEASE
    } session_state_e;

endpackage

//--- logic/frame_reader.sv
module frame_reader
    import frame_buffer_pkg::*;
#(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,
    input  mem_addr_t base_i,
    input  logic      grant_i,
    input  mem_word_t rd_data_i,
    input  logic      rd_data_valid_i,
    input  logic      store_queue_full_i,
    output logic      req_o,
    output mem_addr_t addr_o,
    output logic      store_wr_en_o,
    output pixel_t    store_queue_data_o,
    output logic      done_o
);

    localparam int FRAME_WORDS = FRAME_WIDTH * FRAME_HEIGHT / 2;
    localparam int CNT_W       = $clog2(FRAME_WORDS + 1);

    typedef enum logic [2:0] {
        R_IDLE,
        R_REQ,
        R_WAIT,
        R_LOW,
        R_HIGH
    } rd_state_e;

    rd_state_e        state;
    logic [CNT_W-1:0] word_cnt;
    mem_addr_t        base;
    mem_word_t        rd_word;
    logic             last_word;

    assign req_o     = (state == R_REQ);
    assign addr_o    = base + mem_addr_t'(word_cnt);
    // counter already moved past the word being unpacked
    assign last_word = (word_cnt == CNT_W'(FRAME_WORDS));

    // low pixel first, then the high one
    assign store_wr_en_o      = ((state == R_LOW) || (state == R_HIGH)) && !store_queue_full_i;
    assign store_queue_data_o = (state == R_HIGH) ? rd_word[31:16] : rd_word[15:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= R_IDLE;
            word_cnt <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (start_i) begin
                        word_cnt <= '0;
                        state    <= R_REQ;
                    end
                end
                R_REQ: begin
                    if (grant_i) begin
                        word_cnt <= word_cnt + 1'b1;
                        state    <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    if (rd_data_valid_i) begin
                        state <= R_LOW;
                    end
                end
                R_LOW: begin
                    if (store_wr_en_o) begin
                        state <= R_HIGH;
                    end
                end
                R_HIGH: begin
                    if (store_wr_en_o) begin
                        done_o <= last_word;
                        state  <= last_word ? R_IDLE : R_REQ;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_i && state == R_IDLE) begin
            base <= base_i;
        end
        if (rd_data_valid_i && state == R_WAIT) begin
            rd_word <= rd_data_i;
        end
    end

endmodule

//--- logic/frame_writer.sv
module frame_writer
    import frame_buffer_pkg::*;
#(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,
    input  mem_addr_t base_i,
    input  logic      load_queue_empty_i,
    input  pixel_t    load_queue_data_i,
    input  logic      grant_i,
    output logic      load_rd_en_o,
    output logic      req_o,
    output mem_addr_t addr_o,
    output mem_word_t data_o,
    output logic      done_o
);

    localparam int FRAME_WORDS = FRAME_WIDTH * FRAME_HEIGHT / 2;
    localparam int CNT_W       = $clog2(FRAME_WORDS + 1);
    localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(FRAME_WORDS - 1);

    typedef enum logic [1:0] {
        W_IDLE,
        W_LOW,
        W_HIGH,
        W_REQ
    } wr_state_e;

    wr_state_e        state;
    logic [CNT_W-1:0] word_cnt;
    mem_addr_t        base;
    pixel_t           pix_lo;
    pixel_t           pix_hi;

    // fwft queue, data is valid while not empty
    assign load_rd_en_o = ((state == W_LOW) || (state == W_HIGH)) && !load_queue_empty_i;
    assign req_o        = (state == W_REQ);
    assign addr_o       = base + mem_addr_t'(word_cnt);
    assign data_o       = {pix_hi, pix_lo};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= W_IDLE;
            word_cnt <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (start_i) begin
                        word_cnt <= '0;
                        state    <= W_LOW;
                    end
                end
                W_LOW: begin
                    if (load_rd_en_o) begin
                        state <= W_HIGH;
                    end
                end
                W_HIGH: begin
                    if (load_rd_en_o) begin
                        state <= W_REQ;
                    end
                end
                W_REQ: begin
                    if (grant_i) begin
                        word_cnt <= word_cnt + 1'b1;
                        done_o   <= (word_cnt == LAST_WORD);
                        state    <= (word_cnt == LAST_WORD) ? W_IDLE : W_LOW;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_i && state == W_IDLE) begin
            base <= base_i;
        end
        if (load_rd_en_o && state == W_LOW) begin
            pix_lo <= load_queue_data_i;
        end
        if (load_rd_en_o && state == W_HIGH) begin
            pix_hi <= load_queue_data_i;
        end
    end

endmodule

//--- logic/mem_port.sv
module mem_port
    import frame_buffer_pkg::*;
#(
    parameter int CMD_GAP = 19
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      write_req_i,
    input  mem_addr_t write_addr_i,
    input  mem_word_t write_data_i,
    input  logic      read_req_i,
    input  mem_addr_t read_addr_i,
    input  logic      rd_data_valid_i,
    output logic      write_grant_o,
    output logic      read_grant_o,
    output mem_addr_t addr_o,
    output logic      cmd_o,
    output logic      cmd_en_o,
    output mem_word_t wr_data_o
);

    localparam int GAP_W = $clog2(CMD_GAP + 1);

    logic [GAP_W-1:0] gap_cnt;
    logic             gap_ok;
    logic             rd_pending;
    logic             last_read;
    logic             read_ready;

    assign gap_ok     = (gap_cnt == '0);
    // one read in flight at most
    assign read_ready = read_req_i && !rd_pending;

    // writer goes first only right after a read, which alternates the two
    assign write_grant_o = gap_ok && write_req_i && (!read_ready || last_read);
    assign read_grant_o  = gap_ok && read_ready && !(write_req_i && last_read);

    assign cmd_en_o  = write_grant_o || read_grant_o;
    assign cmd_o     = write_grant_o;
    assign addr_o    = write_grant_o ? write_addr_i : (read_grant_o ? read_addr_i : '0);
    assign wr_data_o = write_grant_o ? write_data_i : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gap_cnt    <= '0;
            rd_pending <= 1'b0;
            last_read  <= 1'b0;
        end else begin
            if (cmd_en_o) begin
                gap_cnt <= GAP_W'(CMD_GAP - 1);
            end else if (!gap_ok) begin
                gap_cnt <= gap_cnt - 1'b1;
            end
            if (read_grant_o) begin
                rd_pending <= 1'b1;
                last_read  <= 1'b1;
            end else begin
                if (rd_data_valid_i) begin
                    rd_pending <= 1'b0;
                end
                if (write_grant_o) begin
                    last_read <= 1'b0;
                end
            end
        end
    end

endmodule

//--- logic/video_frame_buffer.sv
module video_frame_buffer
    import frame_buffer_pkg::*;
#(
    parameter int FRAME_WIDTH   = 640,
    parameter int FRAME_HEIGHT  = 480,
    parameter int STARTUP_DELAY = 152,
    parameter int CMD_GAP       = 19
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      init_done_i,
    output mem_addr_t addr_o,
    output logic      cmd_o,
    output logic      cmd_en_o,
    output mem_word_t wr_data_o,
    input  mem_word_t rd_data_i,
    input  logic      rd_data_valid_i,
    output logic      load_rd_en_o,
    input  logic      load_queue_empty_i,
    input  pixel_t    load_queue_data_i,
    output logic      store_wr_en_o,
    input  logic      store_queue_full_i,
    output pixel_t    store_queue_data_o
);

    logic      write_start;
    logic      read_start;
    mem_addr_t write_base;
    mem_addr_t read_base;
    logic      write_done;
    logic      read_done;
    logic      write_req;
    logic      write_grant;
    mem_addr_t write_addr;
    mem_word_t write_data;
    logic      read_req;
    logic      read_grant;
    mem_addr_t read_addr;

    buffer_manager #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT),
        .STARTUP_DELAY(STARTUP_DELAY)
    ) u_buffer_manager (
        .clk          (clk),
        .rst_n        (rst_n),
        .init_done_i  (init_done_i),
        .write_done_i (write_done),
        .read_done_i  (read_done),
        .write_start_o(write_start),
        .read_start_o (read_start),
        .write_base_o (write_base),
        .read_base_o  (read_base)
    );

    frame_writer #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) u_frame_writer (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_i           (write_start),
        .base_i            (write_base),
        .load_queue_empty_i(load_queue_empty_i),
        .load_queue_data_i (load_queue_data_i),
        .grant_i           (write_grant),
        .load_rd_en_o      (load_rd_en_o),
        .req_o             (write_req),
        .addr_o            (write_addr),
        .data_o            (write_data),
        .done_o            (write_done)
    );

    frame_reader #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) u_frame_reader (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_i           (read_start),
        .base_i            (read_base),
        .grant_i           (read_grant),
        .rd_data_i         (rd_data_i),
        .rd_data_valid_i   (rd_data_valid_i),
        .store_queue_full_i(store_queue_full_i),
        .req_o             (read_req),
        .addr_o            (read_addr),
        .store_wr_en_o     (store_wr_en_o),
        .store_queue_data_o(store_queue_data_o),
        .done_o            (read_done)
    );

    mem_port #(
        .CMD_GAP(CMD_GAP)
    ) u_mem_port (
        .clk            (clk),
        .rst_n          (rst_n),
        .write_req_i    (write_req),
        .write_addr_i   (write_addr),
        .write_data_i   (write_data),
        .read_req_i     (read_req),
        .read_addr_i    (read_addr),
        .rd_data_valid_i(rd_data_valid_i),
        .write_grant_o  (write_grant),
        .read_grant_o   (read_grant),
        .addr_o         (addr_o),
        .cmd_o          (cmd_o),
        .cmd_en_o       (cmd_en_o),
        .wr_data_o      (wr_data_o)
    );

endmodule

//--- verification/psram_model.sv
module psram_model
    import frame_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      cmd_en_i,
    input  logic      cmd_i,
    input  mem_addr_t addr_i,
    input  mem_word_t wr_data_i,
    output mem_word_t rd_data_o,
    output logic      rd_data_valid_o
);
    timeunit 1ns;
    timeprecision 1ps;

    mem_word_t mem [mem_addr_t];
    mem_addr_t rd_addr;
    int        rd_wait;

    // unwritten words still differ at every address
    function automatic mem_word_t fill_word(input mem_addr_t a);
        return {a[10:0], a} ^ 32'h5a5a_a5a5;
    endfunction

    initial begin
        rd_data_o       = '0;
        rd_data_valid_o = 1'b0;
        rd_addr         = '0;
        rd_wait         = 0;
    end

    // commands are stable mid cycle
    always @(negedge clk) begin
        if (cmd_en_i && cmd_i) begin
            mem[addr_i] = wr_data_i;
        end else if (cmd_en_i) begin
            rd_addr = addr_i;
            rd_wait = 1 + int'($urandom % 6);
        end
    end

    always @(posedge clk) begin
        #5;
        rd_data_valid_o = 1'b0;
        if (rd_wait > 0) begin
            rd_wait = rd_wait - 1;
            if (rd_wait == 0) begin
                rd_data_valid_o = 1'b1;
                rd_data_o = mem.exists(rd_addr) ? mem[rd_addr] : fill_word(rd_addr);
            end
        end
    end

endmodule

//--- verification/tb_video_frame_buffer.sv
module tb_video_frame_buffer
    import frame_buffer_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_WORDS    = 16;
    localparam int NUM_FRAMES     = 6;
    localparam int TIMEOUT_CYCLES = 20 * 16 * 12;

    logic      clk;
    logic      rst_n;
    logic      init_done_i;
    mem_addr_t addr_o;
    logic      cmd_o;
    logic      cmd_en_o;
    mem_word_t wr_data_o;
    mem_word_t rd_data_i;
    logic      rd_data_valid_i;
    logic      load_rd_en_o;
    logic      load_queue_empty_i;
    pixel_t    load_queue_data_i;
    logic      store_wr_en_o;
    logic      store_queue_full_i;
    pixel_t    store_queue_data_o;

    pixel_t    exp_pix [$];
    bit        unread [NUM_BUFFERS];
    int        done_cycle [NUM_BUFFERS];
    int        errors, cycle, init_cycles, last_cmd, next_pix;
    int        wr_cnt, wr_words, wr_frames, wr_base;
    int        rd_cnt, rd_frames, rd_base, pushed_pix;
    bit        any_cmd, rd_pending, reading;

    video_frame_buffer #(
        .FRAME_WIDTH  (8),
        .FRAME_HEIGHT (4),
        .STARTUP_DELAY(12),
        .CMD_GAP      (3)
    ) UUT (
        .clk(clk), .rst_n(rst_n), .init_done_i(init_done_i),
        .addr_o(addr_o), .cmd_o(cmd_o), .cmd_en_o(cmd_en_o), .wr_data_o(wr_data_o),
        .rd_data_i(rd_data_i), .rd_data_valid_i(rd_data_valid_i),
        .load_rd_en_o(load_rd_en_o), .load_queue_empty_i(load_queue_empty_i),
        .load_queue_data_i(load_queue_data_i), .store_wr_en_o(store_wr_en_o),
        .store_queue_full_i(store_queue_full_i), .store_queue_data_o(store_queue_data_o)
    );

    psram_model u_psram (
        .clk(clk), .cmd_en_i(cmd_en_o), .cmd_i(cmd_o), .addr_i(addr_o),
        .wr_data_i(wr_data_o), .rd_data_o(rd_data_i), .rd_data_valid_o(rd_data_valid_i)
    );

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic print_summary();
        $display("write frames %0d, read frames %0d, pixels out %0d, errors %0d",
                 wr_frames, rd_frames, pushed_pix, errors);
    endtask

    task automatic check_write();
        int        a;
        mem_word_t exp;
        a = int'(addr_o);
        if (wr_cnt == 0) begin
            assert (a % FRAME_WORDS == 0 && a < NUM_BUFFERS * FRAME_WORDS)
                else report_failure("write frame starts outside the buffer bases");
            assert (!(reading && a == rd_base))
                else report_failure("write frame started in the buffer being read");
            wr_base = a;
            if (a < NUM_BUFFERS * FRAME_WORDS) unread[a / FRAME_WORDS] = 1'b0;
        end else begin
            assert (a == wr_base + wr_cnt) else report_mismatch("addr_o", wr_base + wr_cnt, a);
        end
        // pixel n carries value n with the earlier pixel in the low half
        exp = {pixel_t'(2 * wr_words + 1), pixel_t'(2 * wr_words)};
        assert (wr_data_o == exp) else report_mismatch("wr_data_o", exp, wr_data_o);
        wr_words++;
        wr_cnt++;
        if (wr_cnt == FRAME_WORDS) begin
            wr_cnt = 0;
            wr_frames++;
            if (wr_base < NUM_BUFFERS * FRAME_WORDS) begin
                unread[wr_base / FRAME_WORDS]     = 1'b1;
                done_cycle[wr_base / FRAME_WORDS] = cycle;
            end
        end
    endtask

    task automatic check_read();
        int a;
        bit fresh;
        a = int'(addr_o);
        fresh = 1'b0;
        assert (!rd_pending) else report_failure("read issued while a read is outstanding");
        rd_pending = 1'b1;
        if (rd_cnt == 0) begin
            assert (a % FRAME_WORDS == 0 && a < NUM_BUFFERS * FRAME_WORDS)
                else report_failure("read frame starts outside the buffer bases");
            rd_base = a;
            reading = 1'b1;
            // frames finished long enough ago are surely marked updated
            for (int b = 0; b < NUM_BUFFERS; b++) begin
                if (unread[b] && cycle - done_cycle[b] >= 20) fresh = 1'b1;
            end
            if (a < NUM_BUFFERS * FRAME_WORDS) begin
                assert (!fresh || unread[a / FRAME_WORDS])
                    else report_failure("read frame skipped a completed written frame");
                unread[a / FRAME_WORDS] = 1'b0;
            end
        end else begin
            assert (a == rd_base + rd_cnt) else report_mismatch("addr_o", rd_base + rd_cnt, a);
        end
        rd_cnt = (rd_cnt + 1) % FRAME_WORDS;
    endtask

    always #50 clk = ~clk;

    initial begin
        void'($urandom(32'h628c_85ce));
        clk = 1'b0;
        rst_n = 1'b0;
        init_done_i = 1'b0;
        load_queue_empty_i = 1'b1;
        load_queue_data_i = '0;
        store_queue_full_i = 1'b0;
        repeat (4) @(posedge clk);
        #5 rst_n = 1'b1;
        repeat (20) @(posedge clk);
        #5 init_done_i = 1'b1;
    end

    always @(posedge clk) begin
        #5;
        load_queue_data_i  = pixel_t'(next_pix);
        load_queue_empty_i = ($urandom % 4 == 0);
        store_queue_full_i = ($urandom % 4 == 0);
    end

    // outputs and handshakes are sampled mid cycle
    always @(negedge clk) begin
        cycle++;
        if (!rst_n) begin
            assert (!cmd_en_o && !load_rd_en_o && !store_wr_en_o)
                else report_failure("an output strobe is active during reset");
        end else begin
            if (init_done_i) init_cycles++;
            if (load_rd_en_o) begin
                assert (!load_queue_empty_i) else report_failure("load queue read while empty");
                next_pix++;
            end
            if (store_wr_en_o) begin
                assert (!store_queue_full_i) else report_failure("store queue written while full");
                assert (exp_pix.size() > 0) else report_failure("pixel pushed with no word read");
                if (exp_pix.size() > 0) begin
                    assert (store_queue_data_o == exp_pix[0])
                        else report_mismatch("store_queue_data_o", exp_pix[0], store_queue_data_o);
                    void'(exp_pix.pop_front());
                end
                pushed_pix++;
                if (pushed_pix % (2 * FRAME_WORDS) == 0) begin
                    rd_frames++;
                    reading = 1'b0;
                end
            end
            if (cmd_en_o) begin
                assert (init_cycles >= 12) else report_failure("command before startup delay");
                assert (!any_cmd || cycle - last_cmd >= 3)
                    else report_failure("commands closer than the minimum gap");
                any_cmd = 1'b1;
                last_cmd = cycle;
                if (cmd_o) check_write();
                else check_read();
            end
            if (rd_data_valid_i) begin
                exp_pix.push_back(rd_data_i[15:0]);
                exp_pix.push_back(rd_data_i[31:16]);
                rd_pending = 1'b0;
            end
        end
    end

    initial begin
        wait (wr_frames >= NUM_FRAMES);
        @(negedge clk);
        assert (rd_frames > 0) else report_failure("no frame was read back");
        print_summary();
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * 100);
        report_failure("timeout before all frames were uploaded");
        print_summary();
        $display("TESTS FAILED");
        $finish;
    end

endmodule
